// File: Makefile
# Verilator flow for the write-back stage testbench
TOP := tb_wb_stage
OBJ := obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f project.f --top-module $(TOP) -Mdir $(OBJ) -o sim

run: compile
	@out="$$(./$(OBJ)/sim)"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf $(OBJ)

// File: hdl/retire_fifo.sv
/* Retire FIFO, circular buffer of retire entries between resolver and committer */

`timescale 1ns/1ps

module retire_fifo
(
   input  logic                  clk_in,
   input  logic                  reset,
   input  logic                  push,
   input  wb_pkg::retire_entry_t entry_in,
   input  logic                  pop,
   output wb_pkg::retire_entry_t entry_out,
   output logic                  full,
   output logic                  empty
);
   import wb_pkg::*;

   retire_entry_t        mem [FIFO_DEPTH];       // Entry storage
   logic [FIFO_AW-1:0]   wr_ptr;
   logic [FIFO_AW-1:0]   rd_ptr;
   logic [FIFO_AW:0]     count;                  // Occupancy, 0 to FIFO_DEPTH
   logic                 do_push;
   logic                 do_pop;

   assign full      = (count == (FIFO_AW+1)'(FIFO_DEPTH));
   assign empty     = (count == '0);
   assign do_push   = push & ~full;              // Overflow dropped
   assign do_pop    = pop & ~empty;
   assign entry_out = mem[rd_ptr];               // Head visible the cycle after its push

   always_ff @(posedge clk_in)
   begin
      if (do_push)
         mem[wr_ptr] <= entry_in;
   end

   // Pointers wrap at FIFO_DEPTH
   always_ff @(posedge clk_in)
   begin
      if (reset)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= (wr_ptr == FIFO_AW'(FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
         if (do_pop)
            rd_ptr <= (rd_ptr == FIFO_AW'(FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         case ({do_push, do_pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;            // Both or neither, level unchanged
         endcase
      end
   end

endmodule

// File: hdl/wb_commit.sv
/* Write-back committer: pops retire entries, pulses register, trap and
   reload outputs, and counts retired instructions and traps */

`timescale 1ns/1ps

module wb_commit
(
   input  logic                  clk_in,
   input  logic                  reset,
   input  logic                  cpu_halt,        // Freezes commit
   input  wb_pkg::retire_entry_t entry,           // FIFO head
   input  logic                  empty,
   output logic                  pop,

   // Register file port
   output logic                  gpr_wr,
   output wb_pkg::reg_addr_t     gpr_addr,
   output wb_pkg::word_t         gpr_data,

   // Trap and return
   output logic                  exc_flag,
   output wb_pkg::pc_t           exc_pc,
   output wb_pkg::word_t         exc_tval,
   output wb_pkg::cause_t        exc_cause,
   output logic                  mret,

   // Fetch reload
   output logic                  rld_pc_flag,
   output logic                  rld_ic_flag,
   output wb_pkg::pc_t           rld_pc_addr,

   output wb_pkg::count_t        instret_count,
   output wb_pkg::count_t        trap_count
);
   import wb_pkg::*;

   logic e_trap;

   assign pop    = ~empty & ~cpu_halt;
   assign e_trap = entry[E_TRAP];

   // ------------------------------
   // Pulsed control and counters
   // ------------------------------
   always_ff @(posedge clk_in)
   begin
      if (reset)
      begin
         gpr_wr        <= 1'b0;
         exc_flag      <= 1'b0;
         mret          <= 1'b0;
         rld_pc_flag   <= 1'b0;
         rld_ic_flag   <= 1'b0;
         instret_count <= '0;
         trap_count    <= '0;
      end
      else
      begin
         gpr_wr      <= pop & entry[E_RD_WR];   // One cycle per popped entry
         exc_flag    <= pop & e_trap;
         mret        <= pop & entry[E_MRET];
         rld_pc_flag <= pop & entry[E_RLD];
         rld_ic_flag <= pop & entry[E_RLD_IC];
         if (pop && !e_trap)
            instret_count <= instret_count + 1'b1;
         if (pop && e_trap)
            trap_count <= trap_count + 1'b1;    // Interrupts included
      end
   end

   // Payload holds its last value between pulses
   always_ff @(posedge clk_in)
   begin
      if (pop)
      begin
         if (entry[E_RD_WR])
         begin
            gpr_addr <= entry[E_RD_ADDR +: GPR_ASZ];
            gpr_data <= entry[E_RD_DATA +: XLEN];
         end
         if (e_trap)
         begin
            exc_pc    <= entry[E_EPC +: XLEN];
            exc_tval  <= entry[E_TVAL +: XLEN];
            exc_cause <= entry[E_CAUSE +: CAUSE_W];
         end
         if (entry[E_RLD])
            rld_pc_addr <= entry[E_RLD_ADDR +: XLEN];
      end
   end

endmodule

// File: hdl/wb_pkg.sv
/* Shared widths, cause codes, instruction groups, branch and system ops,
   privilege modes and the retire entry layout for the write-back stage */

package wb_pkg;

   // ------------------------------
   // Widths and sizes
   // ------------------------------
   localparam int XLEN       = 32;                  // Data and address width
   localparam int GPR_ASZ    = 5;                   // Register address width
   localparam int CAUSE_W    = 32;                  // mcause style code width
   localparam int CNT_W      = 32;                  // Retire counter width
   localparam int VEC_W      = 30;                  // Trap vector, word aligned
   localparam int FIFO_DEPTH = 4;                   // Retire FIFO slots
   localparam int FIFO_AW    = $clog2(FIFO_DEPTH);  // FIFO pointer width

   typedef logic [XLEN-1:0]    pc_t;
   typedef logic [XLEN-1:0]    word_t;
   typedef logic [GPR_ASZ-1:0] reg_addr_t;
   typedef logic [CAUSE_W-1:0] cause_t;
   typedef logic [CNT_W-1:0]   count_t;
   typedef logic [VEC_W-1:0]   vec_t;
   typedef logic [2:0]         op_t;               // Raw op field from the memory stage

   // ------------------------------
   // Exception cause codes
   // ------------------------------
   localparam cause_t CAUSE_I_MISALIGN  = 32'd0;   // Branch/jump target misaligned
   localparam cause_t CAUSE_ILLEGAL     = 32'd2;
   localparam cause_t CAUSE_BREAK       = 32'd3;   // EBREAK
   localparam cause_t CAUSE_LD_MISALIGN = 32'd4;
   localparam cause_t CAUSE_LD_FAULT    = 32'd5;
   localparam cause_t CAUSE_ST_MISALIGN = 32'd6;
   localparam cause_t CAUSE_ST_FAULT    = 32'd7;
   localparam cause_t CAUSE_ECALL_BASE  = 32'd8;   // Plus the originating mode

   // Instruction groups as sorted by decode
   typedef enum logic [3:0] {
      ILL_INSTR,
      ALU_INSTR,
      BR_INSTR,
      SYS_INSTR,
      LD_INSTR,
      ST_INSTR
   } ig_type_e;

   typedef enum logic [2:0] {
      B_ADD,                                        // Conditional branches
      B_JAL,
      B_JALR,
      B_MRET
   } br_op_e;

   typedef enum logic [1:0] {
      ECALL,
      EBREAK
   } sys_op_e;

   // Privilege levels, encoding 2 is reserved
   typedef enum logic [1:0] {
      U_MODE = 2'd0,
      S_MODE = 2'd1,
      M_MODE = 2'd3
   } mode_t;

   // ------------------------------
   // Retire entry field positions
   // ------------------------------
   localparam int E_RD_WR    = 0;
   localparam int E_RD_ADDR  = E_RD_WR + 1;
   localparam int E_RD_DATA  = E_RD_ADDR + GPR_ASZ;
   localparam int E_TRAP     = E_RD_DATA + XLEN;
   localparam int E_CAUSE    = E_TRAP + 1;
   localparam int E_EPC      = E_CAUSE + CAUSE_W;
   localparam int E_TVAL     = E_EPC + XLEN;
   localparam int E_RLD      = E_TVAL + XLEN;
   localparam int E_RLD_IC   = E_RLD + 1;
   localparam int E_RLD_ADDR = E_RLD_IC + 1;
   localparam int E_MRET     = E_RLD_ADDR + XLEN;
   localparam int ENTRY_W    = E_MRET + 1;           // 170 bits total

   typedef logic [ENTRY_W-1:0] retire_entry_t;

endpackage

// File: hdl/wb_resolve.sv
/* Write-back resolver: four-phase intake from the memory stage and
   resolution of each instruction into a register write, trap or reload */

`timescale 1ns/1ps

module wb_resolve
(
   input  logic                  clk_in,
   input  logic                  reset,

   // Memory stage handshake and payload
   input  logic                  mem_req,
   output logic                  mem_ack,
   input  wb_pkg::ig_type_e      in_ig_type,
   input  wb_pkg::op_t           in_op,
   input  wb_pkg::pc_t           in_pc,
   input  wb_pkg::word_t         in_instruction,
   input  wb_pkg::pc_t           in_ls_addr,      // Load/store address
   input  wb_pkg::pc_t           in_br_pc,        // Branch/jump target
   input  logic                  in_instr_err,    // Misalignment from execute
   input  logic                  in_ack_fault,    // Bus access fault
   input  logic                  in_inv_flag,     // Store hit instruction space
   input  logic                  in_ci,           // Compressed instruction
   input  wb_pkg::mode_t         in_mode,
   input  logic                  in_rd_wr,
   input  wb_pkg::reg_addr_t     in_rd_addr,
   input  wb_pkg::word_t         in_rd_data,
   input  logic                  in_irq_flag,
   input  wb_pkg::cause_t        in_irq_cause,
   input  wb_pkg::vec_t          trap_vector,

   // Retire FIFO side
   input  logic                  full,
   output logic                  push,
   output wb_pkg::retire_entry_t entry
);
   import wb_pkg::*;

   br_op_e  br_op;
   sys_op_e sys_op;
   logic    rd_wr;
   logic    trap;
   cause_t  cause;
   word_t   tval;
   logic    st_rld;                               // Store into I$ space
   logic    mret_ok;
   pc_t     rld_addr;

   assign br_op  = br_op_e'(in_op);
   assign sys_op = sys_op_e'(in_op[1:0]);

   // ------------------------------
   // Four-phase intake
   // ------------------------------
   // New item: req high while ack still low, taken only with room in the FIFO
   assign push = mem_req & ~mem_ack & ~full;

   always_ff @(posedge clk_in)
   begin
      if (reset)
         mem_ack <= 1'b0;
      else if (push)
         mem_ack <= 1'b1;                         // Raised on the same edge as the push
      else if (!mem_req)
         mem_ack <= 1'b0;                         // Return to idle once req drops
   end

   // ------------------------------
   // Outcome resolution
   // ------------------------------
   always_comb
   begin
      rd_wr   = 1'b0;
      trap    = 1'b0;
      cause   = '0;
      tval    = in_instruction;                   // Default tval is the instruction word
      st_rld  = 1'b0;
      mret_ok = 1'b0;

      if (in_irq_flag)                            // Interrupt wins over the instruction
      begin
         trap  = 1'b1;
         cause = in_irq_cause;
      end
      else
         case (in_ig_type)
            ALU_INSTR:
               rd_wr = in_rd_wr;

            BR_INSTR:
               case (br_op)
                  B_ADD, B_JAL, B_JALR:
                  begin
                     if (in_instr_err)            // Target misaligned
                     begin
                        trap  = 1'b1;
                        cause = CAUSE_I_MISALIGN;
                        tval  = in_br_pc;
                     end
                     else if (br_op != B_ADD)
                        rd_wr = in_rd_wr;         // Link register for JAL/JALR
                  end
                  B_MRET:
                  begin
                     if (in_mode < M_MODE)        // Only legal in machine mode
                     begin
                        trap  = 1'b1;
                        cause = CAUSE_ILLEGAL;
                     end
                     else
                        mret_ok = 1'b1;
                  end
                  default:
                  begin
                     trap  = 1'b1;
                     cause = CAUSE_ILLEGAL;
                  end
               endcase

            SYS_INSTR:
            begin
               trap = 1'b1;                       // Every supported SYS op traps
               case (sys_op)
                  ECALL:   cause = CAUSE_ECALL_BASE + cause_t'(in_mode);
                  EBREAK:  cause = CAUSE_BREAK;
                  default: cause = CAUSE_ILLEGAL;
               endcase
            end

            LD_INSTR:
            begin
               if (in_instr_err || in_ack_fault)
               begin
                  trap  = 1'b1;
                  cause = in_instr_err ? CAUSE_LD_MISALIGN : CAUSE_LD_FAULT;
                  tval  = in_ls_addr;
               end
               else
                  rd_wr = in_rd_wr;
            end

            ST_INSTR:
            begin
               if (in_instr_err || in_ack_fault)
               begin
                  trap  = 1'b1;
                  cause = in_instr_err ? CAUSE_ST_MISALIGN : CAUSE_ST_FAULT;
                  tval  = in_ls_addr;
               end
               else
                  st_rld = in_inv_flag;           // No GPR write for stores
            end

            default:                              // ILL_INSTR and unknown groups
            begin
               trap  = 1'b1;
               cause = CAUSE_ILLEGAL;
            end
         endcase

      // Traps refetch from the vector, store reloads from the next instruction
      if (trap)
         rld_addr = pc_t'({trap_vector, 2'b00});
      else
         rld_addr = in_pc + (in_ci ? pc_t'(2) : pc_t'(4));
   end

   // Pack the retire entry
   assign entry[E_RD_WR]                 = rd_wr;
   assign entry[E_RD_ADDR +: GPR_ASZ]    = in_rd_addr;
   assign entry[E_RD_DATA +: XLEN]       = in_rd_data;
   assign entry[E_TRAP]                  = trap;
   assign entry[E_CAUSE +: CAUSE_W]      = cause;
   assign entry[E_EPC +: XLEN]           = in_pc;   // epc of a trap
   assign entry[E_TVAL +: XLEN]          = tval;
   assign entry[E_RLD]                   = trap | st_rld;
   assign entry[E_RLD_IC]                = st_rld;
   assign entry[E_RLD_ADDR +: XLEN]      = rld_addr;
   assign entry[E_MRET]                  = mret_ok;

endmodule

// File: hdl/wb_stage.sv
/* Write-back stage top: resolver, retire FIFO and committer */

`timescale 1ns/1ps

module wb_stage
(
   input  logic                 clk_in,
   input  logic                 reset,
   input  logic                 cpu_halt,

   // ------------------------------
   // From the memory stage
   // ------------------------------
   input  logic                 mem_req,
   output logic                 mem_ack,
   input  wb_pkg::ig_type_e     in_ig_type,
   input  wb_pkg::op_t          in_op,
   input  wb_pkg::pc_t          in_pc,
   input  wb_pkg::word_t        in_instruction,
   input  wb_pkg::pc_t          in_ls_addr,
   input  wb_pkg::pc_t          in_br_pc,
   input  logic                 in_instr_err,
   input  logic                 in_ack_fault,
   input  logic                 in_inv_flag,
   input  logic                 in_ci,
   input  wb_pkg::mode_t        in_mode,
   input  logic                 in_rd_wr,
   input  wb_pkg::reg_addr_t    in_rd_addr,
   input  wb_pkg::word_t        in_rd_data,
   input  logic                 in_irq_flag,
   input  wb_pkg::cause_t       in_irq_cause,
   input  wb_pkg::vec_t         trap_vector,   // Handler base from CSRs

   // ------------------------------
   // Commit side
   // ------------------------------
   output logic                 gpr_wr,
   output wb_pkg::reg_addr_t    gpr_addr,
   output wb_pkg::word_t        gpr_data,
   output logic                 exc_flag,
   output wb_pkg::pc_t          exc_pc,
   output wb_pkg::word_t        exc_tval,
   output wb_pkg::cause_t       exc_cause,
   output logic                 mret,
   output logic                 rld_pc_flag,
   output logic                 rld_ic_flag,
   output wb_pkg::pc_t          rld_pc_addr,
   output wb_pkg::count_t       instret_count,
   output wb_pkg::count_t       trap_count
);
   import wb_pkg::*;

   logic          push;
   logic          pop;
   logic          full;
   logic          empty;
   retire_entry_t res_entry;                  // Resolver to FIFO
   retire_entry_t head_entry;                 // FIFO head to committer

   wb_resolve i_wb_resolve (
      .clk_in, .reset, .mem_req, .mem_ack, .in_ig_type, .in_op, .in_pc, .in_instruction,
      .in_ls_addr, .in_br_pc, .in_instr_err, .in_ack_fault, .in_inv_flag, .in_ci, .in_mode,
      .in_rd_wr, .in_rd_addr, .in_rd_data, .in_irq_flag, .in_irq_cause, .trap_vector,
      .full, .push, .entry(res_entry));

   retire_fifo i_retire_fifo (
      .clk_in, .reset, .push, .entry_in(res_entry), .pop, .entry_out(head_entry),
      .full, .empty);

   wb_commit i_wb_commit (
      .clk_in, .reset, .cpu_halt, .entry(head_entry), .empty, .pop,
      .gpr_wr, .gpr_addr, .gpr_data, .exc_flag, .exc_pc, .exc_tval, .exc_cause, .mret,
      .rld_pc_flag, .rld_ic_flag, .rld_pc_addr, .instret_count, .trap_count);

endmodule

// File: project.f
hdl/wb_pkg.sv
hdl/retire_fifo.sv
hdl/wb_resolve.sv
hdl/wb_commit.sv
hdl/wb_stage.sv
tb/tb_clock.sv
tb/tb_wb_stage.sv

// File: tb/tb_clock.sv
/* Free-running testbench clock, 100 ns period */

`timescale 1ns/1ps

module tb_clock
(
   output logic clk
);
   initial
   begin
      clk = 1'b0;
      forever #50 clk = ~clk;                    // Half period
   end
endmodule

// File: tb/tb_wb_stage.sv
/* Write-back stage testbench: four-phase driver, outcome model,
   pulse checker with assertions, per-test report and timeout */

`timescale 1ns/1ps

module tb_wb_stage;
   import wb_pkg::*;

   typedef struct packed {
      ig_type_e  ig;
      op_t       op;
      pc_t       pc;
      word_t     instr;
      pc_t       ls_addr;
      pc_t       br_pc;
      logic      ierr;                           // Misaligned target or address
      logic      afault;                         // Bus access fault
      logic      inv;                            // Store into instruction space
      logic      ci;
      mode_t     mode;
      logic      rd_wr;
      reg_addr_t rd_addr;
      word_t     rd_data;
      logic      irq;
      cause_t    irq_cause;
   } item_t;

   typedef struct packed {
      logic      gpr_wr;
      reg_addr_t rd_addr;
      word_t     rd_data;
      logic      trap;
      cause_t    cause;
      pc_t       epc;
      logic      chk_tval;                       // tval defined for this trap
      word_t     tval;
      logic      mret;
      logic      rld;
      logic      rld_ic;
      pc_t       rld_addr;
   } outcome_t;

   logic clk_in;
   logic reset;
   logic cpu_halt;
   logic mem_req;
   logic mem_ack;
   item_t cur;                                   // Payload on the bus
   vec_t tvec;
   logic gpr_wr, exc_flag, mret, rld_pc_flag, rld_ic_flag;
   reg_addr_t gpr_addr;
   word_t gpr_data, exc_tval;
   pc_t exc_pc, rld_pc_addr;
   cause_t exc_cause;
   count_t instret_count, trap_count;

   outcome_t exp_q[$];                           // Pending pulsed outcomes, in order
   int errors = 0;
   int checks = 0;
   int sent = 0;
   int got = 0;                                  // Output pulses seen
   int n_ret = 0;
   int n_trap = 0;
   int cycles = 0;

   tb_clock i_tb_clock (.clk(clk_in));

   wb_stage i_wb_stage (
      .clk_in, .reset, .cpu_halt, .mem_req, .mem_ack,
      .in_ig_type(cur.ig), .in_op(cur.op), .in_pc(cur.pc), .in_instruction(cur.instr),
      .in_ls_addr(cur.ls_addr), .in_br_pc(cur.br_pc), .in_instr_err(cur.ierr),
      .in_ack_fault(cur.afault), .in_inv_flag(cur.inv), .in_ci(cur.ci), .in_mode(cur.mode),
      .in_rd_wr(cur.rd_wr), .in_rd_addr(cur.rd_addr), .in_rd_data(cur.rd_data),
      .in_irq_flag(cur.irq), .in_irq_cause(cur.irq_cause), .trap_vector(tvec),
      .gpr_wr, .gpr_addr, .gpr_data, .exc_flag, .exc_pc, .exc_tval, .exc_cause, .mret,
      .rld_pc_flag, .rld_ic_flag, .rld_pc_addr, .instret_count, .trap_count);

   task automatic check_val(input string name, input logic [31:0] exp_v,
                            input logic [31:0] act_v);
      checks++;
      assert (act_v === exp_v)
      else
      begin
         $display("[FAIL] %0t %s expected %h got %h", $time, name, exp_v, act_v);
         errors++;
      end
   endtask

   function automatic mode_t mode_of(input int m);
      return (m == 0) ? U_MODE : (m == 1) ? S_MODE : M_MODE;
   endfunction

   // Clean item of a group, machine mode, register write requested
   function automatic item_t rand_item(input ig_type_e ig, input op_t op);
      item_t it;
      it = '0;
      it.ig = ig;
      it.op = op;
      it.pc = $urandom() & 32'hffff_fffc;
      it.instr = $urandom();
      it.ls_addr = $urandom();
      it.br_pc = $urandom();
      it.mode = M_MODE;
      it.rd_wr = 1'b1;
      it.rd_addr = 5'($urandom());
      it.rd_data = $urandom();
      it.irq_cause = {1'b1, 31'($urandom_range(0, 15))};
      return it;
   endfunction

   // ------------------------------
   // Outcome model
   // ------------------------------
   function automatic outcome_t predict(input item_t it);
      outcome_t o;
      br_op_e   bop;
      logic     ld;
      o = '0;
      bop = br_op_e'(it.op);
      ld = (it.ig == LD_INSTR);
      o.rd_addr = it.rd_addr;
      o.rd_data = it.rd_data;
      o.epc = it.pc;
      if (it.irq)                                // Interrupt replaces the instruction
      begin
         o.trap = 1'b1;
         o.cause = it.irq_cause;
      end
      else if (it.ig == ALU_INSTR)
         o.gpr_wr = it.rd_wr;
      else if (it.ig == BR_INSTR && bop == B_MRET)
      begin
         o.mret = (it.mode == M_MODE);
         o.trap = (it.mode != M_MODE);           // Illegal below machine mode
         o.cause = CAUSE_ILLEGAL;
      end
      else if (it.ig == BR_INSTR)
      begin
         o.trap = it.ierr;
         o.cause = CAUSE_I_MISALIGN;
         o.chk_tval = it.ierr;
         o.tval = it.br_pc;
         o.gpr_wr = !it.ierr && bop != B_ADD && it.rd_wr;   // Link write
      end
      else if (it.ig == SYS_INSTR)
      begin
         o.trap = 1'b1;
         o.cause = (it.op == 3'(EBREAK)) ? CAUSE_BREAK : CAUSE_ECALL_BASE + 32'(it.mode);
      end
      else if (ld || it.ig == ST_INSTR)
      begin
         o.trap = it.ierr || it.afault;
         o.chk_tval = o.trap;
         o.tval = it.ls_addr;
         o.cause = (ld ? CAUSE_LD_MISALIGN : CAUSE_ST_MISALIGN) + 32'(!it.ierr);
         o.gpr_wr = ld && !o.trap && it.rd_wr;
         o.rld = !ld && !o.trap && it.inv;
         o.rld_ic = o.rld;
         o.rld_addr = it.pc + (it.ci ? 32'd2 : 32'd4);
      end
      else
      begin
         o.trap = 1'b1;
         o.cause = CAUSE_ILLEGAL;
      end
      if (o.trap)
      begin
         o.rld = 1'b1;                           // Refetch from the handler
         o.rld_addr = {tvec, 2'b00};
      end
      return o;
   endfunction

   // ------------------------------
   // Four-phase driver
   // ------------------------------
   task automatic present(input item_t it);
      outcome_t o;
      o = predict(it);
      if (o.gpr_wr || o.trap || o.mret || o.rld)
         exp_q.push_back(o);                     // Silent items only count
      if (o.trap)
         n_trap++;
      else
         n_ret++;
      sent++;
      @(posedge clk_in);
      cur <= it;
      mem_req <= 1'b1;
   endtask

   task automatic finish_handshake();
      @(negedge clk_in);
      while (mem_ack !== 1'b1)
         @(negedge clk_in);
      @(posedge clk_in);
      mem_req <= 1'b0;
      @(negedge clk_in);
      while (mem_ack !== 1'b0)
         @(negedge clk_in);
   endtask

   task automatic send_item(input item_t it);
      present(it);
      finish_handshake();
   endtask

   task automatic wait_drain();
      while (exp_q.size() != 0)
         @(posedge clk_in);
      repeat (4) @(posedge clk_in);              // Trailing silent entries commit
   endtask

   task automatic print_result(input string name, input int err0);
      $display("test %s: %s, %0d errors", name, (errors == err0) ? "ok" : "FAILED",
               errors - err0);
   endtask

   // ------------------------------
   // Test sequences
   // ------------------------------
   task automatic write_back_items();
      item_t it;
      for (int i = 0; i < 4; i++)
      begin
         send_item(rand_item(ALU_INSTR, 3'd0));
         send_item(rand_item(BR_INSTR, 3'(B_JAL)));
         send_item(rand_item(BR_INSTR, 3'(B_JALR)));
      end
      it = rand_item(BR_INSTR, 3'(B_JAL));
      it.ierr = 1'b1;                            // Misaligned jump target
      send_item(it);
      wait_drain();
   endtask

   task automatic trap_items();
      item_t it;
      send_item(rand_item(ILL_INSTR, 3'd0));
      send_item(rand_item(SYS_INSTR, 3'(EBREAK)));
      for (int m = 0; m < 3; m++)
      begin
         it = rand_item(SYS_INSTR, 3'(ECALL));
         it.mode = mode_of(m);
         send_item(it);
         it = rand_item(BR_INSTR, 3'(B_MRET));   // Legal only in M
         it.mode = mode_of(m);
         send_item(it);
      end
      wait_drain();
   endtask

   task automatic load_store_items();
      item_t it;
      for (int k = 0; k < 4; k++)
      begin
         it = rand_item(k < 2 ? LD_INSTR : ST_INSTR, 3'd0);
         it.ierr = (k % 2 == 0);
         it.afault = (k % 2 == 1);
         send_item(it);
      end
      send_item(rand_item(LD_INSTR, 3'd0));
      wait_drain();
   endtask

   task automatic irq_and_reload();
      item_t it;
      for (int g = 0; g < 6; g++)
      begin
         it = rand_item(ig_type_e'(4'(g)), 3'd0);
         it.irq = 1'b1;
         send_item(it);
      end
      for (int c = 0; c < 2; c++)
      begin
         it = rand_item(ST_INSTR, 3'd0);
         it.inv = 1'b1;
         it.ci = 1'(c);
         send_item(it);
      end
      wait_drain();
   endtask

   task automatic halt_backpressure();
      item_t it;
      int    got0;
      @(posedge clk_in);
      cpu_halt <= 1'b1;
      for (int i = 0; i < 4; i++)
         send_item(rand_item(ALU_INSTR, 3'd0));
      present(rand_item(LD_INSTR, 3'd0));        // Fifth item, FIFO full
      got0 = got;
      repeat (12)
      begin
         @(negedge clk_in);
         check_val("mem_ack", 32'd0, 32'(mem_ack));
      end
      check_val("pulses_while_halted", 32'(got0), 32'(got));
      @(posedge clk_in);
      cpu_halt <= 1'b0;
      finish_handshake();
      it = rand_item(ST_INSTR, 3'd0);
      it.inv = 1'b1;
      send_item(it);
      wait_drain();
   endtask

   task automatic random_mix();
      item_t it;
      int    r;
      for (int i = 0; i < 40; i++)
      begin
         it = rand_item(ig_type_e'(4'($urandom_range(0, 5))), 3'($urandom_range(0, 3)));
         if (it.ig == SYS_INSTR)
            it.op[1] = 1'b0;                     // ECALL or EBREAK only
         r = $urandom_range(0, 7);
         it.ierr = (r == 1);
         it.afault = (r == 2);
         it.irq = (r == 3);
         it.inv = 1'($urandom());
         it.ci = 1'($urandom());
         it.rd_wr = 1'($urandom());
         it.mode = mode_of($urandom_range(0, 2));
         send_item(it);
      end
      wait_drain();
      @(negedge clk_in);
      check_val("instret_count", 32'(n_ret), instret_count);
      check_val("trap_count", 32'(n_trap), trap_count);
   endtask

   // ------------------------------
   // Pulse checker
   // ------------------------------
   always @(negedge clk_in)
   begin
      outcome_t e;
      if (!reset && (gpr_wr || exc_flag || mret || rld_pc_flag))
      begin
         got++;
         assert (exp_q.size() != 0)
         else
         begin
            $display("Output pulse at %0t with no outcome pending", $time);
            errors++;
         end
         if (exp_q.size() != 0)
         begin
            e = exp_q.pop_front();
            check_val("gpr_wr", 32'(e.gpr_wr), 32'(gpr_wr));
            if (e.gpr_wr)
            begin
               check_val("gpr_addr", 32'(e.rd_addr), 32'(gpr_addr));
               check_val("gpr_data", e.rd_data, gpr_data);
            end
            check_val("exc_flag", 32'(e.trap), 32'(exc_flag));
            if (e.trap)
            begin
               check_val("exc_cause", e.cause, exc_cause);
               check_val("exc_pc", e.epc, exc_pc);
            end
            if (e.chk_tval)
               check_val("exc_tval", e.tval, exc_tval);
            check_val("mret", 32'(e.mret), 32'(mret));
            check_val("rld_pc_flag", 32'(e.rld), 32'(rld_pc_flag));
            check_val("rld_ic_flag", 32'(e.rld_ic), 32'(rld_ic_flag));
            if (e.rld)
               check_val("rld_pc_addr", e.rld_addr, rld_pc_addr);
         end
      end
   end

   // Limit grows with every item sent
   always @(posedge clk_in)
   begin
      cycles++;
      if (cycles > 40 * sent + 200)
      begin
         $display("Timeout after %0d cycles, handshake or outcomes stalled", cycles);
         $display("Done: errors found");
         $finish;
      end
   end

   initial
   begin
      int e0;
      void'($urandom(32'hfed));
      reset = 1'b1;
      cpu_halt = 1'b0;
      mem_req = 1'b0;
      cur = '0;
      tvec = 30'($urandom());                    // Handler base, fixed for the run
      repeat (10) @(posedge clk_in);
      reset <= 1'b0;
      e0 = errors;
      write_back_items();
      print_result("write_back", e0);
      e0 = errors;
      trap_items();
      print_result("traps", e0);
      e0 = errors;
      load_store_items();
      print_result("load_store", e0);
      e0 = errors;
      irq_and_reload();
      print_result("irq_reload", e0);
      e0 = errors;
      halt_backpressure();
      print_result("halt", e0);
      e0 = errors;
      random_mix();
      print_result("random_mix", e0);
      $display("Tests: 6, items: %0d, checks: %0d, errors: %0d", sent, checks, errors);
      if (errors == 0)
         $display("Done: no errors");
      else
         $display("Done: errors found");
      $finish;
   end

endmodule
